/* common/lsu_pkg.sv */
// Sizes are fixed here; the memory covers only the low 1 KiB and the bus is one master only.
package lsu_pkg;

    // Data and address width.
    localparam int XLEN = 32;

    // One write-mask bit per byte lane.
    localparam int MASK_W = XLEN / 8;

    // Memory depth in words and the word-index width.
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // Stall cycles ahead of every completion cycle.
    localparam int MEM_WAIT = 2;

    // Wide enough to hold the value MEM_WAIT.
    localparam int WAIT_W = $clog2(MEM_WAIT + 1);

    // Memory operations as decoded by the execute stage.
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_SB  = 3'd3,
        OP_LBU = 3'd4,
        OP_LHU = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } lsu_op_e;

endpackage

/* common/mem_bus_if.sv */
// Word-wide bus with no handshake; the master holds its request steady while stall is high.
`timescale 1ns/1ps

interface mem_bus_if;

    logic [lsu_pkg::XLEN-1:0]   addr;   // Always word aligned.
    logic [lsu_pkg::XLEN-1:0]   wdata;
    logic [lsu_pkg::MASK_W-1:0] wmask;
    logic                       we;     // Write valid.
    logic                       sel;    // Request present.
    logic [lsu_pkg::XLEN-1:0]   rdata;
    logic                       stall;

    // Load/store unit side.
    modport master (
        output addr,
        output wdata,
        output wmask,
        output we,
        output sel,
        input  rdata,
        input  stall
    );

    // Memory side.
    modport slave (
        input  addr,
        input  wdata,
        input  wmask,
        input  we,
        input  sel,
        output rdata,
        output stall
    );

endinterface

/* lsu/lsu.sv */
// Combinational only; caller holds op/addr/data until done_o, and accesses must be size aligned.
`timescale 1ns/1ps

module lsu (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic                     hold_i,
    output logic                     done_o,
    input  lsu_pkg::lsu_op_e         op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    output logic [lsu_pkg::XLEN-1:0] rdata_o,
    mem_bus_if.master                bus
);

    logic                       is_store;
    logic [lsu_pkg::MASK_W-1:0] wmask;
    logic [lsu_pkg::XLEN-1:0]   lane_word;
    logic [7:0]                 lane_byte;
    logic [15:0]                lane_half;

    assign is_store = (op_i == lsu_pkg::OP_SB) ||
                      (op_i == lsu_pkg::OP_SH) ||
                      (op_i == lsu_pkg::OP_SW);

    // Request side of the bus.
    assign bus.addr  = {addr_i[lsu_pkg::XLEN-1:2], 2'b00};
    assign bus.wdata = wdata_i;                 // Store data goes out unshifted.
    assign bus.wmask = wmask;
    assign bus.we    = start_i && is_store;
    assign bus.sel   = hold_i ? 1'b0 : start_i; // Pipeline back-pressure.

    assign done_o = start_i ? ~bus.stall : 1'b1;

    always_comb
    begin
        case (op_i)
            lsu_pkg::OP_SB:
            begin
                wmask = lsu_pkg::MASK_W'(1) << addr_i[1:0];
            end
            lsu_pkg::OP_SH:
            begin
                // Upper or lower half of the word.
                wmask = addr_i[1] ? {{(lsu_pkg::MASK_W/2){1'b1}}, {(lsu_pkg::MASK_W/2){1'b0}}} :
                                    {{(lsu_pkg::MASK_W/2){1'b0}}, {(lsu_pkg::MASK_W/2){1'b1}}};
            end
            default:
            begin
                wmask = {lsu_pkg::MASK_W{1'b1}};
            end
        endcase
    end

    // Move the addressed lane down to bit 0.
    assign lane_word = bus.rdata >> {addr_i[1:0], 3'b000};
    assign lane_byte = lane_word[7:0];
    assign lane_half = lane_word[15:0];

    always_comb
    begin
        case (op_i)
            lsu_pkg::OP_LB:  rdata_o = {{(lsu_pkg::XLEN-8){lane_byte[7]}}, lane_byte};
            lsu_pkg::OP_LH:  rdata_o = {{(lsu_pkg::XLEN-16){lane_half[15]}}, lane_half};
            lsu_pkg::OP_LBU: rdata_o = {{(lsu_pkg::XLEN-8){1'b0}}, lane_byte};
            lsu_pkg::OP_LHU: rdata_o = {{(lsu_pkg::XLEN-16){1'b0}}, lane_half};
            default:         rdata_o = bus.rdata; // Word load, stores ignore it.
        endcase
    end

    // Halfword accesses must not cross a half.
    a_half_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (start_i && ((op_i == lsu_pkg::OP_LH) ||
                     (op_i == lsu_pkg::OP_LHU) ||
                     (op_i == lsu_pkg::OP_SH)))
        |-> (addr_i[0] == 1'b0)
    );

    a_word_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (start_i && ((op_i == lsu_pkg::OP_LW) || (op_i == lsu_pkg::OP_SW)))
        |-> (addr_i[1:0] == 2'b00)
    );

    // The caller may not swap the operation under a stalled access.
    a_op_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (start_i && bus.stall) |=> $stable(op_i)
    );

endmodule

/* hdl/data_mem.sv */
// Only address bits 9:2 are decoded, so the low 1 KiB aliases; every access stalls MEM_WAIT cycles.
`timescale 1ns/1ps

module data_mem (
    input  logic     clk_i,
    input  logic     rst_n_i,
    mem_bus_if.slave bus
);

    logic [lsu_pkg::XLEN-1:0]   mem_q [lsu_pkg::MEM_WORDS];
    logic [lsu_pkg::WAIT_W-1:0] wait_cnt_q;
    logic [lsu_pkg::MEM_AW-1:0] word_idx;
    logic                       access_done;

    assign word_idx = bus.addr[lsu_pkg::MEM_AW+1:2];

    // Completion cycle of a selected request.
    assign access_done = bus.sel && (wait_cnt_q == lsu_pkg::WAIT_W'(lsu_pkg::MEM_WAIT));

    assign bus.stall = bus.sel && (wait_cnt_q < lsu_pkg::WAIT_W'(lsu_pkg::MEM_WAIT));
    assign bus.rdata = mem_q[word_idx];

    // Wait-state counter.
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wait_cnt_q <= '0;
        end
        else if (bus.sel && !access_done)
        begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
        else
        begin
            // Back to zero after completion or when idle.
            wait_cnt_q <= '0;
        end
    end

    // Word array with byte enables.
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            for (int w = 0; w < lsu_pkg::MEM_WORDS; w++)
            begin
                mem_q[w] <= '0;
            end
        end
        else if (access_done && bus.we)
        begin
            for (int b = 0; b < lsu_pkg::MASK_W; b++)
            begin
                if (bus.wmask[b])
                begin
                    mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // A write with no lane enabled would be silently lost.
    a_mask_nonzero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        bus.we |-> (bus.wmask != '0)
    );

    // A new request always begins with a wait state.
    a_new_request_stalls : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(bus.sel) |-> bus.stall
    );

endmodule

/* hdl/mem_subsys_top.sv */
// Data-memory stage top; done_o has no meaning while hold_i is high.
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic                     hold_i,
    input  lsu_pkg::lsu_op_e         op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    output logic [lsu_pkg::XLEN-1:0] rdata_o,
    output logic                     done_o
);

    // Word bus between the two blocks.
    mem_bus_if bus_if ();

    lsu i_lsu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .hold_i  (hold_i),
        .done_o  (done_o),
        .op_i    (op_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .bus     (bus_if.master)
    );

    data_mem i_data_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (bus_if.slave)
    );

endmodule

/* verification/tb_mem_subsys.sv */
// Addresses stay in the low 1 KiB, stores carry data in their own lane, and the seed fixes every run.
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int DRIVE_DELAY     = 2;
    localparam int MODEL_BYTES     = lsu_pkg::MEM_WORDS * 4;
    localparam int NUM_RANDOM      = 200;
    localparam int NUM_LANE_ROUNDS = 16;
    localparam int NUM_HOLD        = 8;
    localparam int HOLD_CYCLES     = lsu_pkg::MEM_WAIT + 1;

    // Random stores are each read back, so they count twice.
    localparam int NUM_OPS = lsu_pkg::MEM_WORDS + 2 * NUM_RANDOM + 8 * NUM_LANE_ROUNDS +
                             2 * NUM_HOLD;
    localparam int CYCLE_LIMIT = NUM_OPS * (lsu_pkg::MEM_WAIT + 3) + 200;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     start_i;
    logic                     hold_i;
    lsu_pkg::lsu_op_e         op_i;
    logic [lsu_pkg::XLEN-1:0] addr_i;
    logic [lsu_pkg::XLEN-1:0] wdata_i;
    logic [lsu_pkg::XLEN-1:0] rdata_o;
    logic                     done_o;

    logic [7:0] model_mem [MODEL_BYTES]; // Little-endian byte image.
    integer     seed;
    int         error_count;
    int         check_count;
    int         cycle_count;

    mem_subsys_top i_dut (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .hold_i  (hold_i),
        .op_i    (op_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .done_o  (done_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic is_store_op(input lsu_pkg::lsu_op_e op);
        return (op == lsu_pkg::OP_SB) || (op == lsu_pkg::OP_SH) || (op == lsu_pkg::OP_SW);
    endfunction

    // Size-aligned address inside the modeled range.
    function automatic logic [31:0] align_addr(input lsu_pkg::lsu_op_e op,
                                               input logic [31:0] raw);
        case (op)
            lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  return raw & 32'h0000_03fc;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return raw & 32'h0000_03fe;
            default:                                         return raw & 32'h0000_03ff;
        endcase
    endfunction

    function automatic logic [31:0] predict_load(input lsu_pkg::lsu_op_e op,
                                                 input logic [31:0] addr);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        idx = int'(addr[9:0]);
        case (op)
            lsu_pkg::OP_LB:
            begin
                b = model_mem[idx];
                return {{24{b[7]}}, b};
            end
            lsu_pkg::OP_LBU:
            begin
                b = model_mem[idx];
                return {24'h0, b};
            end
            lsu_pkg::OP_LH:
            begin
                h = {model_mem[idx + 1], model_mem[idx]};
                return {{16{h[15]}}, h};
            end
            lsu_pkg::OP_LHU:
            begin
                h = {model_mem[idx + 1], model_mem[idx]};
                return {16'h0, h};
            end
            lsu_pkg::OP_LW:
            begin
                return {model_mem[idx + 3], model_mem[idx + 2],
                        model_mem[idx + 1], model_mem[idx]};
            end
            default:
            begin
                return 32'h0;
            end
        endcase
    endfunction

    // Store data is not shifted by the LSU, so each written byte comes from its own lane.
    function automatic void store_to_model(input lsu_pkg::lsu_op_e op,
                                           input logic [31:0] addr, input logic [31:0] data);
        int   base;
        logic hit;
        base = int'(addr[9:0]) & ~3;
        for (int lane = 0; lane < 4; lane++)
        begin
            case (op)
                lsu_pkg::OP_SB: hit = (lane == int'(addr[1:0]));
                lsu_pkg::OP_SH: hit = ((lane / 2) == int'(addr[1]));
                lsu_pkg::OP_SW: hit = 1'b1;
                default:        hit = 1'b0;
            endcase
            if (hit)
            begin
                model_mem[base + lane] = data[8*lane +: 8];
            end
        end
    endfunction

    // One access from start to done; also counts the stall cycles.
    task automatic run_op(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] data, output logic [31:0] result);
        int stall_cycles;
        stall_cycles = 0;
        @(posedge clk_i);
        #DRIVE_DELAY;
        start_i = 1'b1;
        op_i    = op;
        addr_i  = addr;
        wdata_i = data;
        @(negedge clk_i);
        while (!done_o)
        begin
            stall_cycles++;
            @(negedge clk_i);
        end
        result = rdata_o;
        check_value(32'(stall_cycles), 32'(lsu_pkg::MEM_WAIT),
                    $sformatf("cycles with done_o low for %s", op.name()));
        @(posedge clk_i); // Write lands on this edge.
        #DRIVE_DELAY;
        start_i = 1'b0;
        #1;
        check_value(32'(done_o), 32'd1, "done_o with start_i low");
    endtask

    task automatic access_and_check(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                                    input logic [31:0] data);
        logic [31:0] expected;
        logic [31:0] result;
        expected = predict_load(op, addr);
        run_op(op, addr, data, result);
        if (is_store_op(op))
        begin
            store_to_model(op, addr, data);
        end
        else
        begin
            check_value(result, expected, $sformatf("%s at %08h", op.name(), addr));
        end
    endtask

    // Store kept off the bus by hold_i, then withdrawn.
    task automatic held_store(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        #DRIVE_DELAY;
        start_i = 1'b1;
        hold_i  = 1'b1;
        op_i    = lsu_pkg::OP_SW;
        addr_i  = addr;
        wdata_i = data;
        repeat (HOLD_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        start_i = 1'b0;
        hold_i  = 1'b0;
    endtask

    initial
    begin
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        lsu_pkg::lsu_op_e op;
        logic [31:0]      addr;
        logic [31:0]      base;
        logic [31:0]      data;
        seed        = 21664;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        rst_n_i     = 1'b0;
        start_i     = 1'b0;
        hold_i      = 1'b0;
        op_i        = lsu_pkg::OP_LW;
        addr_i      = '0;
        wdata_i     = '0;
        for (int i = 0; i < MODEL_BYTES; i++)
        begin
            model_mem[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        repeat (3)
        begin
            @(negedge clk_i);
            check_value(32'(done_o), 32'd1, "done_o idle after reset");
        end
        for (int w = 0; w < lsu_pkg::MEM_WORDS; w++)
        begin
            access_and_check(lsu_pkg::OP_LW, 32'(w * 4), 32'h0);
        end

        // Mixed traffic, every store read back as a word.
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            op   = lsu_pkg::lsu_op_e'(3'($random(seed)));
            addr = align_addr(op, $random(seed));
            data = $random(seed);
            access_and_check(op, addr, data);
            if (is_store_op(op))
            begin
                access_and_check(lsu_pkg::OP_LW, addr & 32'h0000_03fc, 32'h0);
            end
        end

        // Partial stores into one word, then every load width.
        for (int r = 0; r < NUM_LANE_ROUNDS; r++)
        begin
            base = align_addr(lsu_pkg::OP_SW, $random(seed));
            access_and_check(lsu_pkg::OP_SW, base, $random(seed));
            access_and_check(lsu_pkg::OP_SB, base | 32'($random(seed) & 3), $random(seed));
            access_and_check(lsu_pkg::OP_SH, base | 32'($random(seed) & 2), $random(seed));
            access_and_check(lsu_pkg::OP_LW, base, 32'h0);
            access_and_check(lsu_pkg::OP_LB, base | 32'($random(seed) & 3), 32'h0);
            access_and_check(lsu_pkg::OP_LH, base | 32'($random(seed) & 2), 32'h0);
            access_and_check(lsu_pkg::OP_LBU, base | 32'($random(seed) & 3), 32'h0);
            access_and_check(lsu_pkg::OP_LHU, base | 32'($random(seed) & 2), 32'h0);
        end

        for (int k = 0; k < NUM_HOLD; k++)
        begin
            addr = align_addr(lsu_pkg::OP_SW, $random(seed));
            held_store(addr, ~predict_load(lsu_pkg::OP_LW, addr)); // Would be visible.
            access_and_check(lsu_pkg::OP_LW, addr, 32'h0);
        end

        repeat (2) @(posedge clk_i);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/lsu_pkg.sv
common/mem_bus_if.sv
lsu/lsu.sv
hdl/data_mem.sv
hdl/mem_subsys_top.sv
verification/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs tb_mem_subsys with Verilator; exit status 0 only on a passing run.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_subsys \
        -o tb_mem_subsys > build.log 2>&1 \
    && ./obj_dir/tb_mem_subsys > sim.log 2>&1 \
    || { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed, log in sim.log" \
    || { echo "Simulation failed, log in sim.log"; exit 1; }
